/* Bender.yml */
package:
  name: fibcore

sources:
  # packages first
  - files:
      - src/fibDataPkg.sv
      - src/fibCtrlPkg.sv
      - src/regFile.sv
      - src/fibDatapath.sv
      - src/fibSequencer.sv
      - src/fibCore.sv

  # testbench and its included model
  - target: test
    include_dirs:
      - test
    files:
      - test/fibTb.sv

/* compile.f */
+incdir+test
src/fibDataPkg.sv
src/fibCtrlPkg.sv
src/regFile.sv
src/fibDatapath.sv
src/fibSequencer.sv
src/fibCore.sv
test/fibTb.sv

/* src/fibCore.sv */
`timescale 1ns/1ns

module fibCore import fibDataPkg::*, fibCtrlPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  termCount count,
    input  regIndex  rdIdx,
    output logic     termValid,
    output fibWord   termData,
    output termCount termIndex,
    output logic     done,
    output logic     overflow,
    output logic     busy,
    output fibWord   rdData
);

    // sequencer to datapath
    dpCtrl ctrl;
    logic  clearFlags;

    // datapath back to sequencer
    logic  sumCarry;

    // control block
    fibSequencer seq0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .count     (count),
        .sumCarry  (sumCarry),
        .ctrl      (ctrl),
        .clearFlags(clearFlags),
        .termIndex (termIndex),
        .done      (done),
        .busy      (busy)
    );

    // register file, adder and flag
    fibDatapath dp0 (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .clearFlags(clearFlags),
        .rdIdx     (rdIdx),
        .sumCarry  (sumCarry),
        .termValid (termValid),
        .termData  (termData),
        .overflow  (overflow),
        .rdData    (rdData)
    );

endmodule

/* src/fibCtrlPkg.sv */
package fibCtrlPkg;

    //////////////////////////////////////////////////////////////////////
    // sequencer side definitions
    //////////////////////////////////////////////////////////////////////

    // sequencer states
    typedef enum logic [1:0] {
        idle,
        seed0,
        seed1,
        run
    } seqState;

    // source of the register file write value
    // seedNone selects the adder
    typedef enum logic [1:0] {
        seedNone,
        seedZero,
        seedOne
    } seedSelect;

    // everything the sequencer tells the datapath for one cycle
    typedef struct packed {
        seedSelect           seedSel;
        logic                writeEn;
        fibDataPkg::regIndex writeIdx;
        fibDataPkg::regIndex readIdxA;  // term two back
        fibDataPkg::regIndex readIdxB;  // term one back
        logic                emit;
    } dpCtrl;

endpackage

/* src/fibDataPkg.sv */
package fibDataPkg;

    //////////////////////////////////////////////////////////////////////
    // datapath value types
    //////////////////////////////////////////////////////////////////////

    // one fibonacci term as held in the register file
    typedef logic [15:0] fibWord;

    // register file slot
    typedef logic [3:0] regIndex;

    // requested number of terms
    // zero is read as one
    typedef logic [7:0] termCount;

    // slots behind regIndex
    localparam int unsigned NumRegs = 16;

    // seed values for terms 0 and 1
    localparam fibWord termZero = 16'd0;
    localparam fibWord termOne  = 16'd1;

endpackage

/* src/fibDatapath.sv */
`timescale 1ns/1ns

module fibDatapath import fibDataPkg::*, fibCtrlPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  dpCtrl   ctrl,
    input  logic    clearFlags,
    input  regIndex rdIdx,
    output logic    sumCarry,
    output logic    termValid,
    output fibWord  termData,
    output logic    overflow,
    output fibWord  rdData
);

    // sign position of a term
    localparam int SignBit = $bits(fibWord) - 1;

    fibWord opA;
    fibWord opB;
    fibWord sum;
    fibWord writeData;
    logic   setOvf;
    logic   overflowQ;

    // term storage
    regFile regs0 (
        .clk      (clk),
        .rst      (rst),
        .writeEn  (ctrl.writeEn),
        .writeIdx (ctrl.writeIdx),
        .writeData(writeData),
        .readIdxA (ctrl.readIdxA),
        .readIdxB (ctrl.readIdxB),
        .rdIdx    (rdIdx),
        .readA    (opA),
        .readB    (opB),
        .rdData   (rdData)
    );

    //////////////////////////////////////////////////////////////////////
    // adder
    //////////////////////////////////////////////////////////////////////

    assign sum = opA + opB;

    // two's complement overflow of the add
    // terms live in the positive half of the word
    // so a sum that reaches the sign bit does not fit
    assign sumCarry = (opA[SignBit] == opB[SignBit]) && (sum[SignBit] != opA[SignBit]);

    // initial value path or adder result
    always_comb begin
        case (ctrl.seedSel)
            seedZero: writeData = termZero;
            seedOne:  writeData = termOne;
            default:  writeData = sum;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // flag register
    //////////////////////////////////////////////////////////////////////

    // add steps are the only ones on seedNone
    // idle and the seed steps never set the flag
    assign setOvf = sumCarry && (ctrl.seedSel == seedNone);

    always_ff @(posedge clk) begin
        if (rst) begin
            overflowQ <= 1'b0;
        end else if (clearFlags) begin
            overflowQ <= 1'b0;
        end else if (setOvf) begin
            overflowQ <= 1'b1;
        end
    end

    // visible in the cycle of the failed add
    // held until a new run is accepted
    assign overflow = setOvf || (overflowQ && !clearFlags);

    // term output mirrors the write
    assign termValid = ctrl.emit;
    assign termData  = writeData;

endmodule

/* src/fibSequencer.sv */
`timescale 1ns/1ns

module fibSequencer import fibDataPkg::*, fibCtrlPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  termCount count,
    input  logic     sumCarry,
    output dpCtrl    ctrl,
    output logic     clearFlags,
    output termCount termIndex,
    output logic     done,
    output logic     busy
);

    seqState  state;
    termCount termIdx;
    termCount lastIdx;
    regIndex  writeIdx;
    logic     isLast;
    logic     addFail;

    //////////////////////////////////////////////////////////////////////
    // state and counters
    //////////////////////////////////////////////////////////////////////

    // state tracks the step being presented this cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            termIdx  <= '0;
            lastIdx  <= '0;
            writeIdx <= '0;
        end else begin
            case (state)
                idle: begin
                    // start is only looked at here
                    if (start) begin
                        state    <= seed0;
                        termIdx  <= '0;
                        writeIdx <= '0;
                        // a count of 0 ends on term 0 like a count of 1
                        lastIdx  <= (count == '0) ? '0 : count - termCount'(1);
                    end
                end
                seed0, seed1: begin
                    if (isLast) begin
                        state <= idle;
                    end else begin
                        state    <= (state == seed0) ? seed1 : run;
                        termIdx  <= termIdx + termCount'(1);
                        writeIdx <= writeIdx + regIndex'(1);
                    end
                end
                default: begin
                    // run ends on the last term or on a failed add
                    if (isLast || sumCarry) begin
                        state <= idle;
                    end else begin
                        termIdx  <= termIdx + termCount'(1);
                        // wraps around the sixteen slots
                        writeIdx <= writeIdx + regIndex'(1);
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // status outputs
    //////////////////////////////////////////////////////////////////////

    assign busy      = (state != idle);
    assign isLast    = (termIdx == lastIdx);
    assign termIndex = termIdx;

    // add of this cycle left the term range
    assign addFail = (state == run) && sumCarry;

    // first cycle after accept
    assign clearFlags = (state == seed0);

    // normal end rides with the last term
    // overflow end replaces the term that failed
    assign done = (busy && isLast) || addFail;

    //////////////////////////////////////////////////////////////////////
    // datapath control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl.writeIdx = writeIdx;
        // two back and one back
        ctrl.readIdxA = writeIdx - regIndex'(2);
        ctrl.readIdxB = writeIdx - regIndex'(1);
        // failed add is neither stored nor published
        ctrl.writeEn  = busy && !addFail;
        ctrl.emit     = busy && !addFail;
        case (state)
            seed1:   ctrl.seedSel = seedOne;
            run:     ctrl.seedSel = seedNone;
            // parked on the zero seed while idle
            default: ctrl.seedSel = seedZero;
        endcase
    end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ns

module regFile import fibDataPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    writeEn,
    input  regIndex writeIdx,
    input  fibWord  writeData,
    input  regIndex readIdxA,
    input  regIndex readIdxB,
    input  regIndex rdIdx,
    output fibWord  readA,
    output fibWord  readB,
    output fibWord  rdData
);

    // sixteen term slots
    fibWord regs [NumRegs];

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    // all slots back to zero on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeIdx] <= writeData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////

    // adder operands
    // a slot being written still reads its old value this cycle
    assign readA = regs[readIdxA];
    assign readB = regs[readIdxB];

    // readback for the outside world
    assign rdData = regs[rdIdx];

endmodule

/* test/fibModel.svh */
`ifndef FIB_MODEL_SVH
`define FIB_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// reference model of the fibonacci core
//////////////////////////////////////////////////////////////////////

// largest term that fits below the sign bit of a fibWord
localparam int unsigned MaxTerm = 32'h7fff;

// terms the current run should publish, in order
int unsigned expTerm[$];

// current run should end on a failed add
bit expOvf;

// overflow level expected while idle
bit ovfHeld;

// expected register file contents
fibWord regImage[16];

// state right after reset
function automatic void modelReset();
    for (int i = 0; i < 16; i++) begin
        regImage[i] = '0;
    end
    expTerm.delete();
    expOvf  = 1'b0;
    ovfHeld = 1'b0;
endfunction

// builds the term list for one run and updates the register image
function automatic void modelRun(input termCount c);
    int unsigned prev2;
    int unsigned prev1;
    int unsigned cur;
    int          n;
    prev2 = 0;
    prev1 = 0;
    expTerm.delete();
    expOvf = 1'b0;
    // zero asks for one term
    n = (c == 0) ? 1 : int'(c);
    for (int k = 0; k < n; k++) begin
        if (k == 0) begin
            cur = 0;
        end else if (k == 1) begin
            cur = 1;
        end else begin
            cur = prev2 + prev1;
        end
        // out of range add is neither stored nor published
        if (cur > MaxTerm) begin
            expOvf = 1'b1;
            break;
        end
        expTerm.push_back(cur);
        regImage[k % 16] = fibWord'(cur);
        prev2 = prev1;
        prev1 = cur;
    end
    // flag level once the run is over
    ovfHeld = expOvf;
endfunction

`endif

/* test/fibTb.sv */
`timescale 1ns/1ns

module fibTb import fibDataPkg::*; ();

    logic     clk;
    logic     rst;
    logic     start;
    termCount count;
    regIndex  rdIdx;
    logic     termValid;
    fibWord   termData;
    termCount termIndex;
    logic     done;
    logic     overflow;
    logic     busy;
    fibWord   rdData;

    // lcg state
    logic [31:0] lcgState = 32'hfc1a57b3;

    `include "fibModel.svh"

    fibCore dut0 (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .count    (count),
        .rdIdx    (rdIdx),
        .termValid(termValid),
        .termData (termData),
        .termIndex(termIndex),
        .done     (done),
        .overflow (overflow),
        .busy     (busy),
        .rdData   (rdData)
    );

    // 8 ns period
    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            failRun($sformatf("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h",
                              $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // low bits of an lcg are weak
    function automatic int unsigned randBelow(input int unsigned n);
        logic [31:0] r;
        r = nextRand();
        return (r >> 8) % n;
    endfunction

    // returns at the negedge where busy reached level
    task automatic waitBusy(input logic level, input int limit, output int waited);
        bit seen;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < limit) begin
            @(negedge clk);
            waited++;
            seen = (busy === level);
        end
        assert (seen) else begin
            failRun($sformatf("timeout: busy did not go to %0b within %0d cycles",
                              level, limit));
        end
    endtask

    task automatic checkIdle();
        checkValue("busy", busy, 0);
        checkValue("termValid", termValid, 0);
        checkValue("done", done, 0);
        checkValue("overflow", overflow, ovfHeld);
    endtask

    // one idle cycle with a random readback
    task automatic idleCycle();
        @(posedge clk);
        rdIdx <= regIndex'(randBelow(16));
        @(negedge clk);
        checkIdle();
        checkValue($sformatf("rdData[%0d]", rdIdx), rdData, regImage[rdIdx]);
    endtask

    // all sixteen slots against the model image
    task automatic readAll();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            rdIdx <= regIndex'(i);
            @(negedge clk);
            checkIdle();
            checkValue($sformatf("rdData[%0d]", i), rdData, regImage[i]);
        end
    endtask

    // one run, with stray starts during busy at injectPct percent
    task automatic doRun(input termCount c, input int unsigned injectPct);
        int waited;
        int nCycles;
        bit ovfCycle;
        modelRun(c);
        // an overflow end adds one cycle without a term
        nCycles = expTerm.size() + int'(expOvf);
        @(posedge clk);
        start <= 1'b1;
        count <= c;
        @(posedge clk);
        start <= 1'b0;
        waitBusy(1'b1, 8, waited);
        assert (waited == 1) else begin
            failRun("busy did not rise in the cycle after start was accepted");
        end
        for (int k = 0; k < nCycles; k++) begin
            if (k > 0) begin
                @(posedge clk);
                // must not disturb the run in flight
                start <= (randBelow(100) < injectPct);
                count <= termCount'(randBelow(256));
                @(negedge clk);
            end
            ovfCycle = expOvf && (k == expTerm.size());
            checkValue("busy", busy, 1);
            checkValue("termValid", termValid, !ovfCycle);
            if (!ovfCycle) begin
                checkValue("termData", termData, expTerm[k]);
            end
            checkValue("termIndex", termIndex, k);
            checkValue("done", done, k == nCycles - 1);
            checkValue("overflow", overflow, ovfCycle);
        end
        @(posedge clk);
        start <= 1'b0;
        waitBusy(1'b0, 8, waited);
        assert (waited == 1) else begin
            failRun("busy did not fall in the cycle after done");
        end
        checkIdle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        termCount c;
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        count = '0;
        rdIdx = '0;
        modelReset();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // reset state and cleared registers
        checkIdle();
        readAll();

        // zero and one both give a single term
        doRun(termCount'(0), 0);
        readAll();
        doRun(termCount'(1), 0);
        readAll();

        // overflow end after term 23
        doRun(termCount'(30), 0);
        // term 23 of 28657 sits in slot 7
        @(posedge clk);
        rdIdx <= regIndex'(7);
        @(negedge clk);
        checkValue("rdData[7]", rdData, 28657);
        // slot 8 keeps term 8 since term 24 is never stored
        @(posedge clk);
        rdIdx <= regIndex'(8);
        @(negedge clk);
        checkValue("rdData[8]", rdData, 21);
        readAll();

        // next accepted start drops the flag
        doRun(termCount'(5), 0);
        readAll();

        // longest normal run wraps the slots
        doRun(termCount'(24), 30);
        readAll();
        doRun(termCount'(200), 30);
        readAll();

        // random counts, gaps and stray starts
        for (int n = 0; n < 30; n++) begin
            repeat (randBelow(4)) idleCycle();
            if (randBelow(5) == 0) begin
                c = termCount'(25 + randBelow(60));
            end else if (randBelow(10) == 0) begin
                c = '0;
            end else begin
                c = termCount'(1 + randBelow(24));
            end
            doRun(c, 25);
            readAll();
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule
